//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = FpAdderTb
FILELIST = verilog.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- src/Align.sv
// First adder stage that orders operands by magnitude and shifts the smaller one into place
`timescale 1ns/1ps
`default_nettype none

module Align
    import fpAddPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    input  fpWord               opA,
    input  fpWord               opB,
    input  logic                subtract,
    output logic                alignedValid,
    output logic                bigSign,
    output logic                smallSign,
    output logic                effSub,
    output logic [expWidth-1:0] exponentOut,
    output logic [sigWidth-1:0] bigMantissa,
    output logic [sigWidth-1:0] smallMantissa,
    output logic                guardBit,
    output logic                roundBit,
    output logic                stickyBit
);
    // Guard, round and one slot per bit that can fall below them
    localparam int lowWidth = sigWidth + 2;
    localparam int maxShift = sigWidth + 2;

    fpWord                        opBEff;
    logic [sigWidth-1:0]          sigA;
    logic [sigWidth-1:0]          sigB;
    logic                         aBigger;
    fpWord                        bigOp;
    fpWord                        smallOp;
    logic [sigWidth-1:0]          bigSig;
    logic [sigWidth-1:0]          smallSig;
    logic [expWidth-1:0]          expDiff;
    logic [4:0]                   shiftAmount;
    logic [sigWidth+lowWidth-1:0] shiftedSmall;

    always_comb
    begin
        // Subtraction is addition with the sign of B flipped
        opBEff = opB;
        opBEff.sign = opB.sign ^ subtract;

        // Zero exponent means zero, subnormal fractions are dropped
        sigA = (opA.exponent == '0) ? '0 : {1'b1, opA.fraction};
        sigB = (opB.exponent == '0) ? '0 : {1'b1, opB.fraction};

        aBigger = {opA.exponent, sigA} >= {opBEff.exponent, sigB};
        bigOp = aBigger ? opA : opBEff;
        smallOp = aBigger ? opBEff : opA;
        bigSig = aBigger ? sigA : sigB;
        smallSig = aBigger ? sigB : sigA;

        // Past maxShift the whole significand is already below round
        expDiff = bigOp.exponent - smallOp.exponent;
        shiftAmount = (expDiff > maxShift) ? 5'(maxShift) : expDiff[4:0];
        shiftedSmall = {smallSig, {lowWidth{1'b0}}} >> shiftAmount;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            alignedValid <= 1'b0;
        else
            alignedValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        bigSign <= bigOp.sign;
        smallSign <= smallOp.sign;
        effSub <= opA.sign ^ opBEff.sign;
        exponentOut <= bigOp.exponent;
        bigMantissa <= bigSig;
        smallMantissa <= shiftedSmall[sigWidth+lowWidth-1 -: sigWidth];
        guardBit <= shiftedSmall[lowWidth-1];
        roundBit <= shiftedSmall[lowWidth-2];
        stickyBit <= |shiftedSmall[lowWidth-3:0];
    end

    // Common exponent comes from the larger operand
    expNotBelowSmall: assert property (@(posedge clk) disable iff (rst)
        alignedValid |-> exponentOut >= $past(smallOp.exponent))
        else $error("Align: exponent %0d below smaller operand", exponentOut);

endmodule

`default_nettype wire

//--- src/FpAdder.sv
// Top of the three-stage single-precision adder, one operation per cycle, result after three
`timescale 1ns/1ps
`default_nettype none

module FpAdder
    import fpAddPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  inValid,
    input  fpWord opA,
    input  fpWord opB,
    input  logic  subtract,
    output logic  outValid,
    output fpWord result
);
    // Align to MantissaAdd
    logic                alignedValid;
    logic                bigSign;
    logic                smallSign;
    logic                effSub;
    logic [expWidth-1:0] exponentOut;
    logic [sigWidth-1:0] bigMantissa;
    logic [sigWidth-1:0] smallMantissa;
    logic                guardBit;
    logic                roundBit;
    logic                stickyBit;

    // MantissaAdd to Normalize
    logic                sumValid;
    logic [expWidth-1:0] sumExponent;
    logic [sigWidth-1:0] alignedResult;
    logic                carryOut;
    logic                alignedSign;
    logic                sumGuard;
    logic                sumRound;
    logic                sumSticky;

    // Stage wires carry the same names as the ports they join
    Align alignStage
    (
        .*
    );

    MantissaAdd addStage
    (
        .*
    );

    Normalize normStage
    (
        .*
    );

endmodule

`default_nettype wire

//--- src/MantissaAdd.sv
// Second adder stage that adds or subtracts the aligned significands with exact rounding bits
`timescale 1ns/1ps
`default_nettype none

module MantissaAdd
    import fpAddPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                alignedValid,
    input  logic                bigSign,
    input  logic                smallSign,
    input  logic                effSub,
    input  logic [expWidth-1:0] exponentOut,
    input  logic [sigWidth-1:0] bigMantissa,
    input  logic [sigWidth-1:0] smallMantissa,
    input  logic                guardBit,
    input  logic                roundBit,
    input  logic                stickyBit,
    output logic                sumValid,
    output logic [expWidth-1:0] sumExponent,
    output logic [sigWidth-1:0] alignedResult,
    output logic                carryOut,
    output logic                alignedSign,
    output logic                sumGuard,
    output logic                sumRound,
    output logic                sumSticky
);
    logic [sigWidth:0]   sumAdd;
    logic [sigWidth+2:0] diffSub;
    logic [sigWidth+2:0] extResult;
    logic                nextCarry;
    logic                isZero;

    always_comb
    begin
        sumAdd = {1'b0, bigMantissa} + {1'b0, smallMantissa};
        // Borrow runs through guard, round and sticky
        diffSub = {bigMantissa, 3'b000} - {smallMantissa, guardBit, roundBit, stickyBit};

        if (effSub)
        begin
            extResult = diffSub;
            nextCarry = 1'b0;
        end
        else
        begin
            extResult = {sumAdd[sigWidth-1:0], guardBit, roundBit, stickyBit};
            nextCarry = sumAdd[sigWidth];
        end

        isZero = (extResult == '0) && !nextCarry;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            sumValid <= 1'b0;
        else
            sumValid <= alignedValid;
    end

    always_ff @(posedge clk)
    begin
        // Exact zero leaves as positive with a cleared exponent
        sumExponent <= isZero ? '0 : exponentOut;
        alignedSign <= isZero ? 1'b0 : bigSign;
        alignedResult <= extResult[sigWidth+2:3];
        carryOut <= nextCarry;
        sumGuard <= extResult[2];
        sumRound <= extResult[1];
        sumSticky <= extResult[0];
    end

    noCarryOnSub: assert property (@(posedge clk) disable iff (rst)
        alignedValid && effSub |=> !carryOut)
        else $error("MantissaAdd: carry out of a subtraction");

    // Effective operation must agree with the ordered signs
    subMatchesSigns: assert property (@(posedge clk) disable iff (rst)
        alignedValid |-> effSub == (bigSign ^ smallSign))
        else $error("MantissaAdd: effSub disagrees with operand signs");

endmodule

`default_nettype wire

//--- src/Normalize.sv
// Last adder stage that renormalizes the sum, rounds to nearest even and packs the result
`timescale 1ns/1ps
`default_nettype none

module Normalize
    import fpAddPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                sumValid,
    input  logic [expWidth-1:0] sumExponent,
    input  logic [sigWidth-1:0] alignedResult,
    input  logic                carryOut,
    input  logic                alignedSign,
    input  logic                sumGuard,
    input  logic                sumRound,
    input  logic                sumSticky,
    output logic                outValid,
    output fpWord               result
);
    localparam int extWidth = sigWidth + 3;

    logic [extWidth-1:0]        extended;
    logic [extWidth-1:0]        shifted;
    logic [4:0]                 shiftAmount;
    logic [sigWidth-1:0]        normMantissa;
    logic                       normGuard;
    logic                       normRest;
    logic                       roundUp;
    logic [sigWidth:0]          rounded;
    logic [sigWidth-1:0]        finalMantissa;
    logic signed [expWidth+1:0] normExponent;
    logic signed [expWidth+1:0] finalExponent;
    fpWord                      nextResult;

    // Leading zeros over significand and rounding bits
    function automatic logic [4:0] countZeros(input logic [extWidth-1:0] value);
        for (int i = extWidth - 1; i >= 0; i--)
        begin
            if (value[i])
                return 5'(extWidth - 1 - i);
        end
        return 5'(extWidth);
    endfunction

    always_comb
    begin
        extended = {alignedResult, sumGuard, sumRound, sumSticky};
        shiftAmount = countZeros(extended);
        shifted = extended << shiftAmount;

        if (carryOut)
        begin
            // One bit right, the dropped bit becomes guard
            normMantissa = {1'b1, alignedResult[sigWidth-1:1]};
            normGuard = alignedResult[0];
            normRest = sumGuard | sumRound | sumSticky;
            normExponent = $signed({2'b00, sumExponent}) + 1;
        end
        else
        begin
            normMantissa = shifted[extWidth-1:3];
            normGuard = shifted[2];
            normRest = shifted[1] | shifted[0] | sumSticky;
            normExponent = $signed({2'b00, sumExponent})
                - $signed({{(expWidth-3){1'b0}}, shiftAmount});
        end

        // Ties go to the even fraction
        roundUp = normGuard & (normRest | normMantissa[0]);
        rounded = {1'b0, normMantissa} + {{sigWidth{1'b0}}, roundUp};
        finalMantissa = rounded[sigWidth] ? rounded[sigWidth:1] : rounded[sigWidth-1:0];
        finalExponent = rounded[sigWidth] ? normExponent + 1 : normExponent;

        nextResult.sign = alignedSign;
        nextResult.exponent = finalExponent[expWidth-1:0];
        nextResult.fraction = finalMantissa[manWidth-1:0];
        if (extended == '0 && !carryOut)
            nextResult = posZero;
        else if (sumExponent == '0 || finalExponent <= 0)
        begin
            // Underflow flushes to signed zero
            nextResult.exponent = '0;
            nextResult.fraction = '0;
        end
        else if (finalExponent >= $signed({2'b00, expMax}))
        begin
            nextResult.exponent = expMax;
            nextResult.fraction = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            outValid <= 1'b0;
        else
            outValid <= sumValid;
    end

    always_ff @(posedge clk)
    begin
        result <= nextResult;
    end

    infHasNoFraction: assert property (@(posedge clk) disable iff (rst)
        outValid && result.exponent == expMax |-> result.fraction == '0)
        else $error("Normalize: exponent 255 with fraction %h", result.fraction);

endmodule

`default_nettype wire

//--- src/fpAddPkg.sv
// Single-precision field widths, word type and constants imported by every adder stage
`default_nettype none

package fpAddPkg;

    // Field widths of an IEEE-754 single-precision word
    localparam int expWidth = 8;
    localparam int manWidth = 23;

    // Stored fraction plus the hidden one
    localparam int sigWidth = manWidth + 1;

    // All-ones exponent marks infinity
    localparam logic [expWidth-1:0] expMax = '1;

    typedef struct packed
    {
        logic                sign;
        logic [expWidth-1:0] exponent;
        logic [manWidth-1:0] fraction;
    } fpWord;

    localparam fpWord posZero = '0;

endpackage

`default_nettype wire

//--- tb/FpAdderChecker.sv
// Testbench checker for the adder that queues expected sums and checks order, value and latency
`timescale 1ns/1ps
`default_nettype none

module FpAdderChecker
    import fpAddPkg::*;
#(
    parameter int nameBits = 128,
    parameter int latency = 3
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    input  fpWord               expected,
    input  logic [nameBits-1:0] testName,
    input  logic                outValid,
    input  fpWord               result,
    input  logic                endOfRun,
    output int                  mismatchCount,
    output int                  protocolCount,
    output int                  pendingCount
);
    fpWord               expQueue[$];
    logic [nameBits-1:0] nameQueue[$];
    longint              stampQueue[$];
    longint              cycle = 0;
    int                  mismatches = 0;
    int                  protocolErrors = 0;
    int                  pending = 0;
    logic                leftoverChecked = 1'b0;

    assign mismatchCount = mismatches;
    assign protocolCount = protocolErrors;
    assign pendingCount = pending;

    always @(posedge clk)
    begin
        fpWord               want;
        logic [nameBits-1:0] name;
        longint              stamp;
        if (rst && outValid === 1'b1)
        begin
            $display("Protocol error: outValid high during reset at %0t", $time);
            protocolErrors++;
        end
        else if (!rst && outValid === 1'b1)
        begin
            if (expQueue.size() == 0)
            begin
                $display("Protocol error: outValid with no operation in flight at %0t", $time);
                protocolErrors++;
            end
            else
            begin
                want = expQueue.pop_front();
                name = nameQueue.pop_front();
                stamp = stampQueue.pop_front();
                if (result !== want)
                begin
                    $display("** Error: test %0s expected %h actual %h", name, want, result);
                    mismatches++;
                end
                if (cycle - stamp != latency)
                begin
                    $display("Latency error: %0s came out after %0d cycles instead of %0d",
                             name, cycle - stamp, latency);
                    protocolErrors++;
                end
            end
        end
        // Pop before push so a stray output never consumes a fresh entry
        if (!rst && inValid === 1'b1)
        begin
            expQueue.push_back(expected);
            nameQueue.push_back(testName);
            stampQueue.push_back(cycle);
        end
        if (endOfRun && !leftoverChecked)
        begin
            leftoverChecked = 1'b1;
            if (expQueue.size() != 0)
            begin
                $display("Missing results: %0d operations never came out", expQueue.size());
                protocolErrors++;
            end
        end
        cycle++;
        pending = expQueue.size();
    end

endmodule

`default_nettype wire

//--- tb/FpAdderTb.sv
// Testbench top that replays the vector file through the pipelined adder and reports the outcome
`timescale 1ns/1ps
`default_nettype none

module FpAdderTb
    import fpAddPkg::*;
();
    localparam int clockPeriod = 100;
    localparam int resetCycles = 10;
    localparam int groupSize = 6;
    localparam int idleCycles = 3;
    localparam int drainLimit = 8;
    localparam int nameBits = 128;

    typedef struct
    {
        fpWord               a;
        fpWord               b;
        logic                sub;
        fpWord               sum;
        logic [nameBits-1:0] name;
    } vectorRec;

    logic                clk = 1'b0;
    logic                rst;
    logic                inValid;
    fpWord               opA;
    fpWord               opB;
    logic                subtract;
    logic                outValid;
    fpWord               result;
    fpWord               expected;
    logic [nameBits-1:0] testName;
    logic                endOfRun;
    int                  mismatchCount;
    int                  protocolCount;
    int                  pendingCount;
    int                  setupErrors = 0;
    vectorRec            vectors[$];

    FpAdder dut
    (
        .clk, .rst, .inValid, .opA, .opB, .subtract, .outValid, .result
    );

    FpAdderChecker #(.nameBits(nameBits)) resultCheck
    (
        .clk, .rst, .inValid, .expected, .testName, .outValid, .result, .endOfRun,
        .mismatchCount, .protocolCount, .pendingCount
    );

    always #(clockPeriod / 2) clk = ~clk;

    task automatic readVectors();
        int                  fd;
        int                  fields;
        string               line;
        fpWord               a;
        fpWord               b;
        fpWord               sum;
        logic [31:0]         subField;
        logic [nameBits-1:0] name;
        fd = $fopen("tb/fpAddVectors.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file tb/fpAddVectors.txt");
            setupErrors++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            // Comment and blank lines
            if (line.len() < 2 || line[0] == "#")
                continue;
            fields = $sscanf(line, "%h %h %h %h %s", a, b, subField, sum, name);
            if (fields != 5)
            begin
                $display("Malformed vector line: %0s", line);
                setupErrors++;
            end
            else
                vectors.push_back('{a, b, subField[0], sum, name});
        end
        $fclose(fd);
        if (vectors.size() == 0)
        begin
            $display("The vector file holds no vectors");
            setupErrors++;
        end
    endtask

    task automatic applyVectors();
        for (int i = 0; i < vectors.size(); i++)
        begin
            @(posedge clk);
            inValid <= 1'b1;
            opA <= vectors[i].a;
            opB <= vectors[i].b;
            subtract <= vectors[i].sub;
            expected <= vectors[i].sum;
            testName <= vectors[i].name;
            // Idle gap between groups
            if ((i + 1) % groupSize == 0 && i + 1 < vectors.size())
            begin
                @(posedge clk);
                inValid <= 1'b0;
                repeat (idleCycles - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    initial
    begin
        int drained;
        rst = 1'b1;
        // Operations offered during reset never enter the pipeline
        inValid = 1'b1;
        opA = posZero;
        opB = posZero;
        subtract = 1'b0;
        expected = posZero;
        testName = '0;
        endOfRun = 1'b0;
        readVectors();
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        inValid <= 1'b0;
        applyVectors();
        @(negedge clk);
        drained = 0;
        while (pendingCount != 0 && drained < drainLimit)
        begin
            @(negedge clk);
            drained++;
        end
        endOfRun = 1'b1;
        @(negedge clk);
        $display("Error counts: %0d mismatch, %0d protocol, %0d setup",
                 mismatchCount, protocolCount, setupErrors);
        if (mismatchCount == 0 && protocolCount == 0 && setupErrors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        int limitNs;
        @(negedge rst);
        // Allowance covers every vector, the idle gaps and the pipeline drain
        limitNs = (vectors.size() + 20) * clockPeriod;
        #(limitNs);
        $display("Watchdog timeout: the run did not finish %0d ns after reset", limitNs);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/fpAddVectors.txt
# columns: opA opB subtract expected name, numbers in hex
# subtract 1 gives opA - opB, otherwise opA + opB
3f800000 40000000 0 40400000 add_simple
3fc00000 3fc00000 0 40400000 add_carry
40400000 3f800000 1 40000000 sub_simple
3f800000 c0000000 0 bf800000 mixed_sign
c0400000 c0000000 1 bf800000 sub_negs
3f800001 3f800000 1 34000000 cancel_lsb
3fa00000 3f800000 1 3e800000 cancel_two
40490fdb 40490fdb 1 00000000 exact_cancel
c0000000 40000000 0 00000000 cancel_neg
3f800000 33800000 0 3f800000 tie_even_down
3f800001 33800000 0 3f800002 tie_odd_up
3f800000 33800001 0 3f800001 sticky_up
3f800000 33000000 0 3f800000 round_down
3fffffff 33800000 0 40000000 round_carry
3f800000 33800000 1 3f7fffff sub_borrow
7f7fffff 7f7fffff 0 7f800000 overflow_pos
ff7fffff ff7fffff 0 ff800000 overflow_neg
00000000 40490fdb 0 40490fdb zero_left
c0490fdb 00000000 0 c0490fdb zero_right
00000000 3f800000 1 bf800000 zero_minus
00800000 00800001 1 80000000 underflow_neg
00000001 3f800000 0 3f800000 subnormal_in

//--- verilog.f
src/fpAddPkg.sv
src/Align.sv
src/MantissaAdd.sv
src/Normalize.sv
src/FpAdder.sv
tb/FpAdderChecker.sv
tb/FpAdderTb.sv
